//--- design/mcu_pkg.sv
// MCU subsystem constants: address map, opcodes, vectors and FSM state codes

package mcu_pkg;

    // Bus widths
    localparam int addr_w = 16;
    localparam int data_w = 8;

    // Address map
    localparam logic [15:0] rom_base    = 16'hC000;
    localparam logic [15:0] nmi_vector  = 16'hC100;
    localparam logic [15:0] shared_base = 16'h8000;
    localparam logic [15:0] ram_lo      = 16'h0040;
    localparam logic [15:0] ram_hi      = 16'h013F;
    localparam logic [15:0] port_top    = 16'h0028;
    localparam logic [5:0]  port6_addr  = 6'h17;
    localparam int          shared_aw   = 9;

    // Opcodes, 6800 style encodings
    localparam logic [7:0] op_nop = 8'h01;
    localparam logic [7:0] op_ldi = 8'h86;
    localparam logic [7:0] op_lda = 8'hB6;
    localparam logic [7:0] op_sta = 8'hB7;
    localparam logic [7:0] op_add = 8'hBB;
    localparam logic [7:0] op_jmp = 8'h7E;
    localparam logic [7:0] op_beq = 8'h27;
    localparam logic [7:0] op_rti = 8'h3B;

    // Core FSM states
    localparam logic [2:0] st_reset = 3'd0;
    localparam logic [2:0] st_fetch = 3'd1;
    localparam logic [2:0] st_op1   = 3'd2;
    localparam logic [2:0] st_op2   = 3'd3;
    localparam logic [2:0] st_data  = 3'd4;
    localparam logic [2:0] st_nmi   = 3'd5;
    localparam logic [2:0] st_halt  = 3'd6;

endpackage

//--- design/mcu_bus_if.sv
// MCU-side bus between the core and the bus controller

`timescale 1ns/1ps

interface mcu_bus_if;
    import mcu_pkg::*;

    // Driven by the core
    logic [addr_w-1:0] addr;
    logic              rnw;
    logic              vma;
    logic [data_w-1:0] wdata;

    // Driven by the bus controller
    logic [data_w-1:0] rdata;
    logic              cen;

    modport core (output addr, rnw, vma, wdata, input rdata, cen);

    modport ctrl (input addr, rnw, vma, wdata, output rdata, cen);

endinterface

//--- design/mcu_core.sv
// Small accumulator MCU core with fetch/execute FSM, halt and NMI entry

`timescale 1ns/1ps

module mcu_core (
    input  logic     clk,
    input  logic     mcu_rstb,
    mcu_bus_if.core  bus,
    input  logic     halt,
    input  logic     nmi,
    output logic     halted
);
    import mcu_pkg::*;

    logic [2:0]        state;
    logic [2:0]        next_boundary;
    logic [addr_w-1:0] pc;
    logic [addr_w-1:0] saved_pc;
    logic [addr_w-1:0] ea;
    logic [data_w-1:0] ir;
    logic [data_w-1:0] acc;
    logic [data_w-1:0] sum;
    logic              zf;
    logic              nmi_done;
    logic              nmi_req;

    // A level that is still high after entry must drop before it counts again
    assign nmi_req = nmi & ~nmi_done;
    assign sum     = acc + bus.rdata;
    assign halted  = (state == st_halt);

    // Where to go once an instruction completes
    always_comb begin
        if (halt) begin
            next_boundary = st_halt;
        end else if (nmi_req) begin
            next_boundary = st_nmi;
        end else begin
            next_boundary = st_fetch;
        end
    end

    always_comb begin
        bus.vma   = (state != st_reset) && (state != st_halt);
        bus.addr  = (state == st_data) ? ea : pc;
        bus.rnw   = !((state == st_data) && (ir == op_sta));
        bus.wdata = acc;
    end

    always_ff @(posedge clk) begin
        if (!mcu_rstb) begin
            state    <= st_reset;
            pc       <= rom_base;
            saved_pc <= rom_base;
            ea       <= '0;
            ir       <= op_nop;
            acc      <= '0;
            zf       <= 1'b0;
            nmi_done <= 1'b0;
        end else begin
            if (!nmi) begin
                nmi_done <= 1'b0;
            end
            if (bus.cen) begin
                case (state)
                    st_fetch: begin
                        ir <= bus.rdata;
                        pc <= pc + 16'd1;
                        case (bus.rdata)
                            op_ldi, op_beq, op_lda, op_sta, op_add, op_jmp: begin
                                state <= st_op1;
                            end
                            op_rti: begin
                                pc    <= saved_pc;
                                state <= next_boundary;
                            end
                            // NOP and anything undecoded
                            default: state <= next_boundary;
                        endcase
                    end
                    st_op1: begin
                        pc <= pc + 16'd1;
                        if (ir == op_ldi) begin
                            acc   <= bus.rdata;
                            zf    <= (bus.rdata == '0);
                            state <= next_boundary;
                        end else if (ir == op_beq) begin
                            // Signed offset from the byte after the operand
                            if (zf) begin
                                pc <= pc + 16'd1 + {{8{bus.rdata[7]}}, bus.rdata};
                            end
                            state <= next_boundary;
                        end else begin
                            ea[15:8] <= bus.rdata;
                            state    <= st_op2;
                        end
                    end
                    st_op2: begin
                        ea[7:0] <= bus.rdata;
                        if (ir == op_jmp) begin
                            pc    <= {ea[15:8], bus.rdata};
                            state <= next_boundary;
                        end else begin
                            pc    <= pc + 16'd1;
                            state <= st_data;
                        end
                    end
                    st_data: begin
                        if (ir == op_lda) begin
                            acc <= bus.rdata;
                            zf  <= (bus.rdata == '0);
                        end else if (ir == op_add) begin
                            acc <= sum;
                            zf  <= (sum == '0);
                        end
                        state <= next_boundary;
                    end
                    st_nmi: begin
                        saved_pc <= pc;
                        pc       <= nmi_vector;
                        nmi_done <= 1'b1;
                        state    <= st_fetch;
                    end
                    // Reset and halt both leave through the boundary check
                    default: state <= next_boundary;
                endcase
            end
        end
    end

    // Core stays off the bus for as long as halt is held
    assert property (@(posedge clk) disable iff (!mcu_rstb) halted && halt |=> !bus.vma);

endmodule

//--- design/mcu_bus_ctrl.sv
// Bus controller: address decode, read mux and clock enable with ROM/shared waits

`timescale 1ns/1ps

module mcu_bus_ctrl (
    input  logic                      clk,
    input  logic                      mcu_rstb,
    mcu_bus_if.ctrl                   bus,
    input  logic                      cen6,
    input  logic [mcu_pkg::data_w-1:0] rom_data,
    input  logic                      rom_ok,
    output logic                      rom_cs,
    output logic [13:0]               rom_addr,
    input  logic [mcu_pkg::data_w-1:0] ram_rdata,
    input  logic [mcu_pkg::data_w-1:0] shared_rdata,
    input  logic [mcu_pkg::data_w-1:0] port_rdata,
    output logic                      ram_cs,
    output logic                      shared_cs,
    output logic                      port_cs
);
    import mcu_pkg::*;

    logic rom_wait;
    logic shared_rd;
    logic shared_ok;

    assign rom_addr = bus.addr[13:0];

    // Address map decode, only for valid cycles
    always_comb begin
        rom_cs    = bus.vma && (bus.addr[15:14] == rom_base[15:14]);
        shared_cs = bus.vma && (bus.addr[15:12] == shared_base[15:12]);
        ram_cs    = bus.vma && (bus.addr >= ram_lo) && (bus.addr <= ram_hi);
        port_cs   = bus.vma && (bus.addr < port_top);
    end

    always_comb begin
        if (port_cs) begin
            bus.rdata = port_rdata;
        end else if (shared_cs) begin
            bus.rdata = shared_rdata;
        end else if (ram_cs) begin
            bus.rdata = ram_rdata;
        end else begin
            bus.rdata = rom_data;
        end
    end

    assign rom_wait  = rom_cs & ~rom_ok;
    assign shared_rd = shared_cs & bus.rnw;

    // Shared RAM read data is registered, so one enable slot is skipped
    always_ff @(posedge clk) begin
        if (!mcu_rstb) begin
            shared_ok <= 1'b0;
        end else if (bus.cen) begin
            shared_ok <= 1'b0;
        end else if (cen6 && shared_rd) begin
            shared_ok <= 1'b1;
        end
    end

    assign bus.cen = cen6 & ~rom_wait & (~shared_rd | shared_ok);

    // ROM sees a steady address until it answers
    assert property (@(posedge clk) disable iff (!mcu_rstb) rom_wait |=> $stable(rom_addr));

endmodule

//--- design/mcu_ports.sv
// MCU I/O ports: read-back registers, port 6 output and the NMI latch

`timescale 1ns/1ps

module mcu_ports (
    input  logic                      clk,
    input  logic                      mcu_rstb,
    input  logic                      port_cs,
    input  logic                      rnw,
    input  logic                      cen,
    input  logic [5:0]                addr,
    input  logic [mcu_pkg::data_w-1:0] wdata,
    input  logic                      nmi_set,
    output logic [mcu_pkg::data_w-1:0] rdata,
    output logic                      nmi,
    output logic                      irqmain
);
    import mcu_pkg::*;

    logic [data_w-1:0] port_map [0:31];
    logic [1:0]        p6_dout;
    logic              port_we;
    logic              nmi_set_d;

    assign port_we = port_cs & ~rnw & cen;
    assign rdata   = port_map[addr[4:0]];
    assign irqmain = p6_dout[1];

    always_ff @(posedge clk) begin
        if (port_we) begin
            port_map[addr[4:0]] <= wdata;
        end
    end

    // Only the IRQ and latch control bits of port 6 go anywhere
    always_ff @(posedge clk) begin
        if (!mcu_rstb) begin
            p6_dout <= '0;
        end else if (port_we && addr == port6_addr) begin
            p6_dout <= wdata[1:0];
        end
    end

    // Rising edge of nmi_set sets the latch; port 6 bit 0 low holds it clear
    always_ff @(posedge clk) begin
        if (!mcu_rstb) begin
            nmi_set_d <= 1'b0;
            nmi       <= 1'b0;
        end else begin
            nmi_set_d <= nmi_set;
            if (!p6_dout[0]) begin
                nmi <= 1'b0;
            end else if (nmi_set && !nmi_set_d) begin
                nmi <= 1'b1;
            end
        end
    end

endmodule

//--- design/mcu_memories.sv
// Internal work RAM and the dual-port shared RAM with the host write gate

`timescale 1ns/1ps

module mcu_memories (
    input  logic                         clk,
    input  logic                         cen,
    input  logic                         ram_cs,
    input  logic                         shared_cs,
    input  logic                         rnw,
    input  logic [mcu_pkg::shared_aw-1:0] addr,
    input  logic [mcu_pkg::data_w-1:0]    wdata,
    output logic [mcu_pkg::data_w-1:0]    ram_rdata,
    output logic [mcu_pkg::data_w-1:0]    shared_rdata,
    input  logic                         halted,
    input  logic [mcu_pkg::shared_aw-1:0] cpu_ab,
    input  logic                         cpu_wrn,
    input  logic                         com_cs,
    input  logic [mcu_pkg::data_w-1:0]    cpu_dout,
    output logic [mcu_pkg::data_w-1:0]    shared_dout
);
    import mcu_pkg::*;

    logic [data_w-1:0] work_ram [0:255];
    logic [data_w-1:0] shared_ram [0:(1 << shared_aw)-1];
    logic              ram_we;
    logic              mcu_we;
    logic              host_we;

    assign ram_we  = ram_cs & ~rnw & cen;
    assign mcu_we  = shared_cs & ~rnw & cen;
    // Host only gets in while the core sits halted
    assign host_we = com_cs & ~cpu_wrn & halted;

    // Work RAM reads back within the same enable cycle
    assign ram_rdata = work_ram[addr[7:0]];

    always_ff @(posedge clk) begin
        if (ram_we) begin
            work_ram[addr[7:0]] <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (mcu_we) begin
            shared_ram[addr] <= wdata;
        end else if (host_we) begin
            shared_ram[cpu_ab] <= cpu_dout;
        end
        shared_rdata <= shared_ram[addr];
        shared_dout  <= shared_ram[cpu_ab];
    end

    // MCU side is off the shared RAM whenever a host write lands
    assert property (@(posedge clk) host_we |-> !shared_cs);

endmodule

//--- design/mcu_subsys.sv
// MCU subsystem top: core, bus controller, ports and memories

`timescale 1ns/1ps

module mcu_subsys (
    input  logic                         clk,
    input  logic                         mcu_rstb,
    input  logic                         cen6,
    input  logic [mcu_pkg::shared_aw-1:0] cpu_ab,
    input  logic                         cpu_wrn,
    input  logic [mcu_pkg::data_w-1:0]    cpu_dout,
    output logic [mcu_pkg::data_w-1:0]    shared_dout,
    input  logic                         com_cs,
    output logic                         mcu_ban,
    input  logic                         mcu_nmi_set,
    input  logic                         mcu_halt,
    output logic                         mcu_irqmain,
    output logic [13:0]                  rom_addr,
    input  logic [mcu_pkg::data_w-1:0]    rom_data,
    output logic                         rom_cs,
    input  logic                         rom_ok
);
    import mcu_pkg::*;

    logic              ram_cs;
    logic              shared_cs;
    logic              port_cs;
    logic [data_w-1:0] ram_rdata;
    logic [data_w-1:0] shared_rdata;
    logic [data_w-1:0] port_rdata;
    logic              nmi;
    logic              halted;

    mcu_bus_if bus_if ();

    // Host sees the MCU as busy whenever its bus cycle is valid
    assign mcu_ban = bus_if.vma;

    mcu_core u_core (
        .clk      (clk),
        .mcu_rstb (mcu_rstb),
        .bus      (bus_if.core),
        .halt     (mcu_halt),
        .nmi      (nmi),
        .halted   (halted)
    );

    mcu_bus_ctrl u_bus_ctrl (
        .clk          (clk),
        .mcu_rstb     (mcu_rstb),
        .bus          (bus_if.ctrl),
        .cen6         (cen6),
        .rom_data     (rom_data),
        .rom_ok       (rom_ok),
        .rom_cs       (rom_cs),
        .rom_addr     (rom_addr),
        .ram_rdata    (ram_rdata),
        .shared_rdata (shared_rdata),
        .port_rdata   (port_rdata),
        .ram_cs       (ram_cs),
        .shared_cs    (shared_cs),
        .port_cs      (port_cs)
    );

    mcu_ports u_ports (
        .clk      (clk),
        .mcu_rstb (mcu_rstb),
        .port_cs  (port_cs),
        .rnw      (bus_if.rnw),
        .cen      (bus_if.cen),
        .addr     (bus_if.addr[5:0]),
        .wdata    (bus_if.wdata),
        .nmi_set  (mcu_nmi_set),
        .rdata    (port_rdata),
        .nmi      (nmi),
        .irqmain  (mcu_irqmain)
    );

    mcu_memories u_memories (
        .clk          (clk),
        .cen          (bus_if.cen),
        .ram_cs       (ram_cs),
        .shared_cs    (shared_cs),
        .rnw          (bus_if.rnw),
        .addr         (bus_if.addr[shared_aw-1:0]),
        .wdata        (bus_if.wdata),
        .ram_rdata    (ram_rdata),
        .shared_rdata (shared_rdata),
        .halted       (halted),
        .cpu_ab       (cpu_ab),
        .cpu_wrn      (cpu_wrn),
        .com_cs       (com_cs),
        .cpu_dout     (cpu_dout),
        .shared_dout  (shared_dout)
    );

endmodule

//--- testbench/tb_mcu_rom.sv
// Behavioral program ROM answering after a random delay, loaded with the test program

`timescale 1ns/1ps

module tb_mcu_rom (
    input  logic        clk,
    input  logic        rom_cs,
    input  logic [13:0] rom_addr,
    output logic [7:0]  rom_data,
    output logic        rom_ok
);
    import mcu_pkg::*;

    // Main loop at rom_base
    localparam logic [7:0] main_prog [17] = '{
        op_lda, shared_base[15:8], 8'h00,
        op_add, rom_base[15:8], 8'hF0,
        op_sta, shared_base[15:8], 8'h01,
        op_ldi, 8'h03,
        op_sta, 8'h00, {2'b00, port6_addr},
        op_jmp, rom_base[15:8], rom_base[7:0]
    };

    // NMI handler at nmi_vector
    localparam logic [7:0] nmi_prog [20] = '{
        op_lda, shared_base[15:8], 8'h10,
        op_add, rom_base[15:8], 8'hF1,
        op_sta, shared_base[15:8], 8'h10,
        op_ldi, 8'h02,
        op_sta, 8'h00, {2'b00, port6_addr},
        op_ldi, 8'h03,
        op_sta, 8'h00, {2'b00, port6_addr},
        op_rti
    };

    logic [7:0]  mem [0:16383];
    logic [13:0] last_addr = '0;
    logic        active    = 1'b0;
    logic [1:0]  lat       = 2'd0;
    logic [1:0]  next_lat  = 2'd0;
    logic [1:0]  cnt       = 2'd0;
    logic        fresh;
    integer      seed      = 32'hbbca;
    logic [4:0]  k;

    initial begin
        for (k = '0; k < 5'd17; k++) begin
            mem[rom_base[13:0] + 14'(k)] = main_prog[k];
        end
        for (k = '0; k < 5'd20; k++) begin
            mem[nmi_vector[13:0] + 14'(k)] = nmi_prog[k];
        end
        // Constant operands of the two ADDs
        mem[rom_base[13:0] + 14'h0F0] = 8'h25;
        mem[rom_base[13:0] + 14'h0F1] = 8'h01;
    end

    // New address or a gap in rom_cs starts a new access
    assign fresh    = !active || (rom_addr != last_addr);
    assign rom_data = mem[rom_addr];
    assign rom_ok   = rom_cs && (fresh ? (next_lat == 2'd0) : (cnt >= lat));

    always @(posedge clk) begin
        active    <= rom_cs;
        last_addr <= rom_addr;
        if (rom_cs && fresh) begin
            // Latency of the next access drawn ahead of time
            lat      <= next_lat;
            next_lat <= 2'($random(seed));
            cnt      <= 2'd1;
        end else if (cnt != 2'd3) begin
            cnt <= cnt + 2'd1;
        end
    end

endmodule

//--- testbench/tb_mcu_subsys.sv
// MCU subsystem testbench driving the host bus, halt and NMI with assertion checks

`timescale 1ns/1ps

module tb_mcu_subsys;
    import mcu_pkg::*;

    localparam int          halt_bound  = 30;
    localparam int          cycle_limit = 4000;
    localparam int          nmi_pulses  = 3;
    // RTI closes the 20 byte NMI handler
    localparam logic [13:0] rti_addr    = nmi_vector[13:0] + 14'd19;

    logic                 clk  = 1'b0;
    logic                 cen6 = 1'b0;
    logic                 mcu_rstb;
    logic [shared_aw-1:0] cpu_ab;
    logic                 cpu_wrn;
    logic [data_w-1:0]    cpu_dout;
    logic [data_w-1:0]    shared_dout;
    logic                 com_cs;
    logic                 mcu_ban;
    logic                 mcu_nmi_set;
    logic                 mcu_halt;
    logic                 mcu_irqmain;
    logic [13:0]          rom_addr;
    logic [data_w-1:0]    rom_data;
    logic                 rom_cs;
    logic                 rom_ok;

    logic [13:0]          rom_addr_d = '0;
    int                   halt_wait  = 0;
    int                   cycles     = 0;
    logic                 check_dout;
    logic [data_w-1:0]    exp_dout;
    logic                 irq_armed;
    int                   err_reset = 0;
    int                   err_halt  = 0;
    int                   err_dout  = 0;
    int                   err_irq   = 0;
    int                   err_rom   = 0;
    integer               seed      = 32'hbbca;
    logic [data_w-1:0]    rand_byte;
    int                   pulse_idx;

    mcu_subsys dut0 (
        .clk         (clk),
        .mcu_rstb    (mcu_rstb),
        .cen6        (cen6),
        .cpu_ab      (cpu_ab),
        .cpu_wrn     (cpu_wrn),
        .cpu_dout    (cpu_dout),
        .shared_dout (shared_dout),
        .com_cs      (com_cs),
        .mcu_ban     (mcu_ban),
        .mcu_nmi_set (mcu_nmi_set),
        .mcu_halt    (mcu_halt),
        .mcu_irqmain (mcu_irqmain),
        .rom_addr    (rom_addr),
        .rom_data    (rom_data),
        .rom_cs      (rom_cs),
        .rom_ok      (rom_ok)
    );

    tb_mcu_rom u_rom (
        .clk      (clk),
        .rom_cs   (rom_cs),
        .rom_addr (rom_addr),
        .rom_data (rom_data),
        .rom_ok   (rom_ok)
    );

    always #50 clk = ~clk;

    // Clock enable on every other cycle
    always @(posedge clk) begin
        cen6 <= ~cen6;
    end

    always @(posedge clk) begin
        rom_addr_d <= rom_addr;
        cycles     <= cycles + 1;
        if (mcu_halt && mcu_ban) begin
            halt_wait <= halt_wait + 1;
        end else begin
            halt_wait <= 0;
        end
        if (cycles == cycle_limit) begin
            $display("Timeout after %0d cycles, the test sequence did not finish", cycles);
            $display("** FAIL **");
            $finish;
        end
    end

    // Reset and the first cycle after it
    assert property (@(posedge clk) !mcu_rstb |=> !mcu_irqmain)
    else begin
        err_reset = err_reset + 1;
        $display("Mismatch at %0t: mcu_irqmain = %b, expected 0", $time, $sampled(mcu_irqmain));
    end

    assert property (@(posedge clk) disable iff (!mcu_rstb) halt_wait <= halt_bound)
    else begin
        err_halt = err_halt + 1;
        $display("At %0t mcu_ban is still high %0d cycles after mcu_halt", $time, halt_bound);
    end

    assert property (@(posedge clk) check_dout |-> (shared_dout == exp_dout))
    else begin
        err_dout = err_dout + 1;
        $display("Mismatch at %0t: shared_dout = %02h, expected %02h",
                 $time, $sampled(shared_dout), $sampled(exp_dout));
    end

    // Port 6 keeps bit 1 set once the program has run
    assert property (@(posedge clk) irq_armed |-> mcu_irqmain)
    else begin
        err_irq = err_irq + 1;
        $display("Mismatch at %0t: mcu_irqmain = %b, expected 1", $time, $sampled(mcu_irqmain));
    end

    // ROM address held until the ROM answers
    assert property (@(posedge clk) disable iff (!mcu_rstb)
                     rom_cs && !rom_ok |=> (rom_addr == rom_addr_d))
    else begin
        err_rom = err_rom + 1;
        $display("Mismatch at %0t: rom_addr = %04h, expected %04h",
                 $time, $sampled(rom_addr), $sampled(rom_addr_d));
    end

    task automatic host_write(input logic [shared_aw-1:0] a, input logic [data_w-1:0] d);
        @(posedge clk);
        cpu_ab   <= a;
        cpu_dout <= d;
        com_cs   <= 1'b1;
        cpu_wrn  <= 1'b0;
        @(posedge clk);
        com_cs   <= 1'b0;
        cpu_wrn  <= 1'b1;
    endtask

    // Registered read, so the check lands two edges after the address
    task automatic check_shared_byte(input logic [shared_aw-1:0] a, input logic [data_w-1:0] d);
        @(posedge clk);
        cpu_ab <= a;
        @(posedge clk);
        exp_dout   <= d;
        check_dout <= 1'b1;
        @(posedge clk);
        check_dout <= 1'b0;
    endtask

    task automatic halt_core();
        @(posedge clk);
        mcu_halt <= 1'b1;
        @(negedge clk);
        while (mcu_ban) @(negedge clk);
    endtask

    task automatic pulse_nmi();
        @(posedge clk);
        mcu_nmi_set <= 1'b1;
        @(posedge clk);
        mcu_nmi_set <= 1'b0;
    endtask

    // Handler is done once its RTI has been fetched
    task automatic wait_rti_fetch();
        @(negedge clk);
        while (!(rom_cs && rom_ok && rom_addr == rti_addr)) @(negedge clk);
        while (rom_cs && rom_addr == rti_addr) @(negedge clk);
    endtask

    initial begin
        mcu_rstb    = 1'b0;
        cpu_ab      = '0;
        cpu_wrn     = 1'b1;
        cpu_dout    = '0;
        com_cs      = 1'b0;
        mcu_nmi_set = 1'b0;
        mcu_halt    = 1'b1;
        check_dout  = 1'b0;
        exp_dout    = '0;
        irq_armed   = 1'b0;
        repeat (2) @(posedge clk);
        mcu_rstb <= 1'b1;
        // Core leaves reset into halt after one enable cycle
        repeat (4) @(posedge clk);
        rand_byte = 8'($random(seed));
        host_write(9'h000, rand_byte);
        host_write(9'h001, 8'h00);
        host_write(9'h020, 8'h5A);
        check_shared_byte(9'h000, rand_byte);
        check_shared_byte(9'h020, 8'h5A);
        @(posedge clk);
        mcu_halt <= 1'b0;
        @(negedge clk);
        while (!mcu_irqmain) @(negedge clk);
        @(posedge clk);
        irq_armed <= 1'b1;
        // Core owns the bus here, so this write must be dropped
        host_write(9'h020, 8'hA5);
        check_shared_byte(9'h020, 8'h5A);
        halt_core();
        check_shared_byte(9'h001, rand_byte + 8'h25);
        host_write(9'h010, 8'h00);
        check_shared_byte(9'h010, 8'h00);
        @(posedge clk);
        mcu_halt <= 1'b0;
        for (pulse_idx = 0; pulse_idx < nmi_pulses; pulse_idx++) begin
            pulse_nmi();
            wait_rti_fetch();
        end
        halt_core();
        check_shared_byte(9'h010, 8'(nmi_pulses));
        @(posedge clk);
        $display("Errors: reset %0d, halt %0d, shared_dout %0d, irqmain %0d, rom_addr %0d",
                 err_reset, err_halt, err_dout, err_irq, err_rom);
        if (err_reset + err_halt + err_dout + err_irq + err_rom == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- src.f
design/mcu_pkg.sv
design/mcu_bus_if.sv
design/mcu_core.sv
design/mcu_bus_ctrl.sv
design/mcu_ports.sv
design/mcu_memories.sv
design/mcu_subsys.sv
testbench/tb_mcu_rom.sv
testbench/tb_mcu_subsys.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the MCU subsystem testbench with Verilator, runs it and checks for the pass line

set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
        --top-module tb_mcu_subsys -Mdir obj_dir -f src.f; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_mcu_subsys)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qxF '** PASS **' <<< "$sim_out"; then
    exit 0
fi
echo "Pass line not found in simulation output"
exit 1
